// ==== common/cache_pkg.sv ====
// widths, sizes and shared types of the cache bank
// sizes must be powers of two; field widths are derived from them
`default_nettype none

package cache_pkg;

    localparam int word_bits       = 32;
    localparam int words_per_line  = 4;
    localparam int num_lines       = 16;
    localparam int addr_bits       = 12;
    localparam int line_index_bits = $clog2(num_lines);
    localparam int word_sel_bits   = $clog2(words_per_line);
    localparam int tag_bits        = addr_bits - line_index_bits - word_sel_bits;
    localparam int req_tag_bits    = 4;
    localparam int mreq_depth      = 4;
    localparam int crsp_depth      = 2;
    // items that can sit in stage 0 and stage 1 at once
    localparam int pipe_stages     = 2;

    typedef logic [word_bits-1:0]                 word_t;
    typedef word_t [words_per_line-1:0]           line_t;
    typedef logic [line_index_bits-1:0]           line_index_t;
    typedef logic [tag_bits-1:0]                  line_tag_t;
    typedef logic [word_sel_bits-1:0]             word_sel_t;
    typedef logic [word_bits/8-1:0]               byteen_t;
    typedef logic [words_per_line*word_bits/8-1:0] line_byteen_t;
    typedef logic [req_tag_bits-1:0]              req_tag_t;

    typedef struct packed {
        line_tag_t   tag;
        line_index_t index;
        word_sel_t   word_sel;
    } word_addr_t;

    typedef struct packed {
        line_tag_t   tag;
        line_index_t index;
    } line_addr_t;

    typedef struct packed {
        logic       rw;
        word_addr_t addr;
        byteen_t    byteen;
        word_t      data;
        req_tag_t   tag;
    } core_req_t;

    typedef struct packed {
        word_t    data;
        req_tag_t tag;
    } core_rsp_t;

    typedef struct packed {
        logic         rw;
        line_addr_t   addr;
        line_byteen_t byteen;
        line_t        data;
    } mem_req_t;

    typedef enum logic [1:0] {
        slot_idle,
        slot_reserved,
        slot_wait_fill,
        slot_replay
    } miss_state_t;

endpackage

`default_nettype wire

// ==== design/sync_fifo.sv ====
// circular buffer with show-ahead output, data visible the cycle after push
// no overflow or underflow protection; callers check full and empty
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int width = 8,
    parameter int depth = 4
) (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               push,
    input  wire               pop,
    input  wire [width-1:0]   data_in,
    output logic [width-1:0]  data_out,
    output logic              empty,
    output logic              free_ok,
    output logic              full
);

    localparam int ptr_bits   = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_bits = $clog2(depth + 1);

    logic [width-1:0]      mem [depth];
    logic [ptr_bits-1:0]   rd_ptr;
    logic [ptr_bits-1:0]   wr_ptr;
    logic [count_bits-1:0] count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= data_in;
    end

    assign data_out = mem[rd_ptr];
    assign empty    = (count == '0);
    assign full     = (count == count_bits'(depth));
    // room left after this cycle's push for everything still in the stages
    assign free_ok  = (int'(count) + int'(push)) <= (depth - cache_pkg::pipe_stages);

endmodule

`default_nettype wire

// ==== design/cache_init.sv ====
// walks every line index once after reset, one per cycle
// busy stays high for exactly num_lines cycles
`timescale 1ns/1ps
`default_nettype none

module cache_init (
    input  wire                     clk,
    input  wire                     rst_n,
    output logic                    busy,
    output cache_pkg::line_index_t  line
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b1;
            line <= '0;
        end else if (busy) begin
            line <= line + 1'b1;
            // last index reached, sweep done
            if (line == cache_pkg::line_index_t'(cache_pkg::num_lines - 1)) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/cache_miss_slot.sv ====
// single outstanding read miss; holds the parked request until replayed
// reserve is only legal from idle, release and allocate only from reserved
`timescale 1ns/1ps
`default_nettype none

module cache_miss_slot (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   reserve,
    input  wire                   release_slot,
    input  wire                   allocate,
    input  wire cache_pkg::core_req_t alloc_req,
    input  wire                   fill,
    input  wire                   replay_ready,
    output logic                  idle,
    output logic                  wait_fill,
    output logic                  replay_valid,
    output cache_pkg::core_req_t  replay_req
);

    cache_pkg::miss_state_t state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cache_pkg::slot_idle;
        end else begin
            case (state)
                cache_pkg::slot_idle: begin
                    if (reserve) state <= cache_pkg::slot_reserved;
                end
                cache_pkg::slot_reserved: begin
                    // hit answers directly, miss waits for its line
                    if (release_slot) begin
                        state <= cache_pkg::slot_idle;
                    end else if (allocate) begin
                        state <= cache_pkg::slot_wait_fill;
                    end
                end
                cache_pkg::slot_wait_fill: begin
                    if (fill) state <= cache_pkg::slot_replay;
                end
                cache_pkg::slot_replay: begin
                    if (replay_ready) state <= cache_pkg::slot_idle;
                end
                default: state <= cache_pkg::slot_idle;
            endcase
        end
    end

    // parked read, also gives the line address of the fill
    always_ff @(posedge clk) begin
        if (allocate) replay_req <= alloc_req;
    end

    assign idle         = (state == cache_pkg::slot_idle);
    assign wait_fill    = (state == cache_pkg::slot_wait_fill);
    assign replay_valid = (state == cache_pkg::slot_replay);

endmodule

`default_nettype wire

// ==== store/cache_tags.sv ====
// tag and valid bit per line, direct mapped
// lookup is combinational; init and fill take effect at the clock edge
`timescale 1ns/1ps
`default_nettype none

module cache_tags (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          init,
    input  wire cache_pkg::line_index_t  init_line,
    input  wire                          fill,
    input  wire cache_pkg::line_index_t  write_line,
    input  wire cache_pkg::line_tag_t    write_tag,
    input  wire cache_pkg::line_index_t  lookup_line,
    input  wire cache_pkg::line_tag_t    lookup_tag,
    output logic                         hit
);

    logic [cache_pkg::num_lines-1:0] valid;
    cache_pkg::line_tag_t            tag_mem [cache_pkg::num_lines];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (init) begin
            valid[init_line] <= 1'b0;
        end else if (fill) begin
            valid[write_line] <= 1'b1;
        end
    end

    // tag only matters once valid is set
    always_ff @(posedge clk) begin
        if (fill && !init) tag_mem[write_line] <= write_tag;
    end

    assign hit = valid[lookup_line] && (tag_mem[lookup_line] == lookup_tag);

endmodule

`default_nettype wire

// ==== store/cache_data.sv ====
// line storage; whole-line fill or byte-masked single-word write
// read_line is registered every cycle from the addressed line
`timescale 1ns/1ps
`default_nettype none

module cache_data (
    input  wire                          clk,
    input  wire                          fill,
    input  wire cache_pkg::line_t        fill_line,
    input  wire                          write,
    input  wire cache_pkg::word_sel_t    word_sel,
    input  wire cache_pkg::byteen_t      byteen,
    input  wire cache_pkg::word_t        write_word,
    input  wire cache_pkg::line_index_t  line,
    output cache_pkg::line_t             read_line
);

    cache_pkg::line_t data_mem [cache_pkg::num_lines];

    always_ff @(posedge clk) begin
        if (fill) begin
            data_mem[line] <= fill_line;
        end else if (write) begin
            // only the enabled byte lanes of the selected word
            for (int b = 0; b < cache_pkg::word_bits / 8; b++) begin
                if (byteen[b]) begin
                    data_mem[line][word_sel][b*8 +: 8] <= write_word[b*8 +: 8];
                end
            end
        end
    end

    // old contents on a same-cycle write
    always_ff @(posedge clk) begin
        read_line <= data_mem[line];
    end

endmodule

`default_nettype wire

// ==== design/cache_bank.sv ====
// direct-mapped write-through cache bank, no write allocate, one read miss at a time
// stage 0 does lookup and array writes, stage 1 routes responses and memory requests
// core requests wait for the init sweep and for any read in flight
`timescale 1ns/1ps
`default_nettype none

module cache_bank (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       core_req_valid,
    input  wire cache_pkg::core_req_t core_req,
    output logic                      core_req_ready,
    output logic                      core_rsp_valid,
    output cache_pkg::core_rsp_t      core_rsp,
    input  wire                       core_rsp_ready,
    output logic                      mem_req_valid,
    output cache_pkg::mem_req_t       mem_req,
    input  wire                       mem_req_ready,
    input  wire                       mem_rsp_valid,
    input  wire cache_pkg::line_t     mem_rsp_data,
    output logic                      mem_rsp_ready
);

    logic                   init_busy;
    cache_pkg::line_index_t init_line;
    logic                   slot_idle;
    logic                   slot_wait_fill;
    logic                   replay_valid;
    logic                   replay_ready;
    cache_pkg::core_req_t   replay_req;
    logic                   stall;
    logic                   replay_fire;
    logic                   fill_fire;
    logic                   creq_fire;
    logic                   valid_sel;
    cache_pkg::core_req_t   req_sel;

    logic                   valid_st0;
    logic                   is_fill_st0;
    logic                   is_replay_st0;
    cache_pkg::core_req_t   req_st0;
    cache_pkg::line_t       fill_data_st0;
    logic                   hit_st0;
    logic                   do_fill_st0;
    logic                   do_write_st0;

    logic                   valid_st1;
    logic                   is_fill_st1;
    logic                   is_replay_st1;
    logic                   hit_st1;
    cache_pkg::core_req_t   req_st1;
    cache_pkg::line_t       read_line_st1;
    logic                   do_read_st1;
    logic                   do_write_st1;
    logic                   read_miss_st1;

    cache_pkg::core_rsp_t   crsp_in;
    logic                   crsp_push;
    logic                   crsp_pop;
    logic                   crsp_empty;
    logic                   crsp_full;
    cache_pkg::mem_req_t    mreq_in;
    logic                   mreq_push;
    logic                   mreq_pop;
    logic                   mreq_empty;
    logic                   mreq_free_ok;

    cache_init i_cache_init (
        .clk   (clk),
        .rst_n (rst_n),
        .busy  (init_busy),
        .line  (init_line)
    );

    // arbitration: init, then replay, then fill, then core
    assign replay_ready   = !init_busy && !stall;
    assign mem_rsp_ready  = slot_wait_fill && !stall;
    assign core_req_ready = !init_busy && slot_idle && !replay_valid && !mem_rsp_valid
                         && mreq_free_ok && !stall;

    assign replay_fire = replay_valid && replay_ready;
    assign fill_fire   = mem_rsp_valid && mem_rsp_ready;
    assign creq_fire   = core_req_valid && core_req_ready;
    assign valid_sel   = replay_fire || fill_fire || creq_fire;
    // a fill has no address of its own, it takes the parked read's
    assign req_sel     = creq_fire ? core_req : replay_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_st0 <= 1'b0;
            valid_st1 <= 1'b0;
        end else if (!stall) begin
            valid_st0 <= valid_sel;
            valid_st1 <= valid_st0;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            is_fill_st0   <= fill_fire;
            is_replay_st0 <= replay_fire;
            req_st0       <= req_sel;
            fill_data_st0 <= mem_rsp_data;
            is_fill_st1   <= is_fill_st0;
            is_replay_st1 <= is_replay_st0;
            hit_st1       <= hit_st0;
            req_st1       <= req_st0;
        end
    end

    assign do_fill_st0  = valid_st0 && is_fill_st0;
    assign do_write_st0 = valid_st0 && !is_fill_st0 && req_st0.rw;

    cache_tags i_cache_tags (
        .clk         (clk),
        .rst_n       (rst_n),
        .init        (init_busy),
        .init_line   (init_line),
        .fill        (do_fill_st0 && !stall),
        .write_line  (req_st0.addr.index),
        .write_tag   (req_st0.addr.tag),
        .lookup_line (req_st0.addr.index),
        .lookup_tag  (req_st0.addr.tag),
        .hit         (hit_st0)
    );

    // while stalled, keep reloading the line that stage 1 is answering from
    cache_data i_cache_data (
        .clk        (clk),
        .fill       (do_fill_st0 && !stall),
        .fill_line  (fill_data_st0),
        .write      (do_write_st0 && hit_st0 && !stall),
        .word_sel   (req_st0.addr.word_sel),
        .byteen     (req_st0.byteen),
        .write_word (req_st0.data),
        .line       (stall ? req_st1.addr.index : req_st0.addr.index),
        .read_line  (read_line_st1)
    );

    assign do_read_st1   = valid_st1 && !is_fill_st1 && !req_st1.rw;
    assign do_write_st1  = valid_st1 && !is_fill_st1 && req_st1.rw;
    assign read_miss_st1 = do_read_st1 && !hit_st1 && !is_replay_st1;
    assign stall         = do_read_st1 && hit_st1 && crsp_full;

    cache_miss_slot i_cache_miss_slot (
        .clk          (clk),
        .rst_n        (rst_n),
        .reserve      (creq_fire && !core_req.rw),
        .release_slot (do_read_st1 && hit_st1 && !is_replay_st1 && !stall),
        .allocate     (read_miss_st1),
        .alloc_req    (req_st1),
        .fill         (fill_fire),
        .replay_ready (replay_ready),
        .idle         (slot_idle),
        .wait_fill    (slot_wait_fill),
        .replay_valid (replay_valid),
        .replay_req   (replay_req)
    );

    // read hit response
    assign crsp_push    = do_read_st1 && hit_st1 && !stall;
    assign crsp_pop     = core_rsp_valid && core_rsp_ready;
    assign crsp_in.data = read_line_st1[req_st1.addr.word_sel];
    assign crsp_in.tag  = req_st1.tag;

    sync_fifo #(
        .width ($bits(cache_pkg::core_rsp_t)),
        .depth (cache_pkg::crsp_depth)
    ) i_crsp_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (crsp_push),
        .pop      (crsp_pop),
        .data_in  (crsp_in),
        .data_out (core_rsp),
        .empty    (crsp_empty),
        .free_ok  (),
        .full     (crsp_full)
    );

    assign core_rsp_valid = !crsp_empty;

    // fill request on a first read miss, write-through on every write
    assign mreq_push         = read_miss_st1 || do_write_st1;
    assign mreq_pop          = mem_req_valid && mem_req_ready;
    assign mreq_in.rw        = req_st1.rw;
    assign mreq_in.addr.tag  = req_st1.addr.tag;
    assign mreq_in.addr.index = req_st1.addr.index;
    assign mreq_in.data      = {cache_pkg::words_per_line{req_st1.data}};

    always_comb begin
        mreq_in.byteen = '1;
        if (req_st1.rw) begin
            mreq_in.byteen = '0;
            mreq_in.byteen[req_st1.addr.word_sel * (cache_pkg::word_bits / 8) +:
                           (cache_pkg::word_bits / 8)] = req_st1.byteen;
        end
    end

    sync_fifo #(
        .width ($bits(cache_pkg::mem_req_t)),
        .depth (cache_pkg::mreq_depth)
    ) i_mreq_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (mreq_push),
        .pop      (mreq_pop),
        .data_in  (mreq_in),
        .data_out (mem_req),
        .empty    (mreq_empty),
        .free_ok  (mreq_free_ok),
        .full     ()
    );

    assign mem_req_valid = !mreq_empty;

endmodule

`default_nettype wire

// ==== test/cache_bank_tb.sv ====
// vector-driven testbench for the cache bank, run from the project root
// memory model starts as address xor 5A5A0000 and answers fills after 1 to 4 cycles
`timescale 1ns/1ps
`default_nettype none

module cache_bank_tb;

    localparam int num_vectors = 32;
    localparam int vec_words   = 7;
    localparam int timeout     = 200;
    localparam logic [31:0] init_pattern = 32'h5A5A0000;

    logic                  clk;
    logic                  rst_n;
    logic                  core_req_valid;
    cache_pkg::core_req_t  core_req;
    logic                  core_req_ready;
    logic                  core_rsp_valid;
    cache_pkg::core_rsp_t  core_rsp;
    logic                  core_rsp_ready;
    logic                  mem_req_valid;
    cache_pkg::mem_req_t   mem_req;
    logic                  mem_req_ready;
    logic                  mem_rsp_valid;
    cache_pkg::line_t      mem_rsp_data;
    logic                  mem_rsp_ready;

    logic [31:0]           vec_mem [num_vectors * vec_words];
    cache_pkg::word_t      mem_model [1 << cache_pkg::addr_bits];
    cache_pkg::core_rsp_t  exp_rsp [$];
    cache_pkg::core_req_t  exp_wr [$];
    cache_pkg::line_addr_t exp_fill [$];
    cache_pkg::line_addr_t fill_pending [$];

    integer      seed = 78;
    logic [31:0] rand_word;
    logic        backpressure;
    logic        timed_out;
    int          checks;
    int          errors;
    int          tests;
    int          fill_count;
    int          write_count;
    int          test_num;
    int          err_base;
    int          chk_base;
    int          fill_base;
    int          wr_base;
    int          want_fills;
    int          want_writes;
    string       cur_test;

    cache_bank i_cache_bank (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_data   (mem_rsp_data),
        .mem_rsp_ready  (mem_rsp_ready)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        rand_word <= $random(seed);
    end

    // random back-pressure on both ready inputs during the back-pressure test
    // response side pops slower than reads arrive, so the queue fills and stalls
    always @(posedge clk) begin
        #1;
        core_rsp_ready = backpressure ? (rand_word[0] & rand_word[3]) : 1'b1;
        mem_req_ready  = backpressure ? (rand_word[1] | rand_word[2]) : 1'b1;
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s %s expected %h actual %h", cur_test, what, expected, actual);
        end
    endtask

    function automatic string test_name(input int num);
        case (num)
            1: return "cold_read";
            2: return "hit";
            3: return "write_through";
            4: return "merge";
            5: return "conflict";
            6: return "backpressure";
            default: return "unknown";
        endcase
    endfunction

    // memory side: applies writes to the model and queues fills
    always @(posedge clk) begin : mem_monitor
        cache_pkg::core_req_t    wr;
        cache_pkg::line_addr_t   fl;
        cache_pkg::line_byteen_t be;
        int                      base;
        if (mem_req_valid && mem_req_ready) begin
            base = int'(mem_req.addr) * cache_pkg::words_per_line;
            if (mem_req.rw) begin
                write_count++;
                for (int w = 0; w < cache_pkg::words_per_line; w++) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_req.byteen[w*4+b]) begin
                            mem_model[base+w][b*8 +: 8] = mem_req.data[w][b*8 +: 8];
                        end
                    end
                end
                if (exp_wr.size() == 0) begin
                    errors++;
                    $display("%s: memory write without a matching core write", cur_test);
                end else begin
                    wr = exp_wr.pop_front();
                    be = cache_pkg::line_byteen_t'(wr.byteen) << (4 * wr.addr.word_sel);
                    check_value("write line", 32'({wr.addr.tag, wr.addr.index}),
                                32'(mem_req.addr));
                    check_value("write byteen", 32'(be), 32'(mem_req.byteen));
                    check_value("write word", wr.data, mem_req.data[wr.addr.word_sel]);
                end
            end else begin
                fill_count++;
                fill_pending.push_back(mem_req.addr);
                if (exp_fill.size() == 0) begin
                    errors++;
                    $display("%s: fill request that no read should cause", cur_test);
                end else begin
                    fl = exp_fill.pop_front();
                    check_value("fill line", 32'(fl), 32'(mem_req.addr));
                end
            end
        end
    end

    // answers the oldest fill with the current model line
    initial begin : fill_responder
        int                    gap;
        int                    cycles;
        logic                  taken;
        cache_pkg::line_addr_t fill_line;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        forever begin
            @(posedge clk);
            #1;
            if (fill_pending.size() != 0 && !timed_out) begin
                gap = int'(rand_word[5:4]);
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
                fill_line = fill_pending[0];
                for (int w = 0; w < cache_pkg::words_per_line; w++) begin
                    mem_rsp_data[w] = mem_model[int'(fill_line) * cache_pkg::words_per_line + w];
                end
                mem_rsp_valid = 1'b1;
                taken  = 1'b0;
                cycles = 0;
                while (!taken && cycles < timeout) begin
                    @(posedge clk);
                    taken = mem_rsp_ready;
                    cycles++;
                end
                if (!taken) begin
                    $display("timeout: fill response for line %h was never taken", fill_line);
                    timed_out = 1'b1;
                end
                #1;
                mem_rsp_valid = 1'b0;
                void'(fill_pending.pop_front());
            end
        end
    end

    always @(posedge clk) begin : rsp_monitor
        cache_pkg::core_rsp_t want;
        if (core_rsp_valid && core_rsp_ready) begin
            if (exp_rsp.size() == 0) begin
                errors++;
                $display("%s: core response without an outstanding read", cur_test);
            end else begin
                want = exp_rsp.pop_front();
                check_value("response tag", 32'(want.tag), 32'(core_rsp.tag));
                check_value("read data", want.data, core_rsp.data);
            end
        end
    end

    task automatic send_request(input int v);
        cache_pkg::core_req_t  req;
        cache_pkg::core_rsp_t  want;
        cache_pkg::line_addr_t la;
        int                    base;
        int                    cycles;
        logic                  accepted;
        base        = v * vec_words;
        req.rw      = vec_mem[base+1][0];
        req.addr    = vec_mem[base+2][cache_pkg::addr_bits-1:0];
        req.byteen  = vec_mem[base+3][3:0];
        req.data    = vec_mem[base+4];
        req.tag     = cache_pkg::req_tag_t'(v);
        core_req       = req;
        core_req_valid = 1'b1;
        accepted = 1'b0;
        cycles   = 0;
        while (!accepted && !timed_out) begin
            @(posedge clk);
            accepted = core_req_ready;
            cycles++;
            if (!accepted && cycles >= timeout) begin
                $display("timeout: request %0d of %s was never accepted", v, cur_test);
                timed_out = 1'b1;
            end
        end
        if (accepted) begin
            if (req.rw) begin
                exp_wr.push_back(req);
                want_writes++;
            end else begin
                want.data = vec_mem[base+5];
                want.tag  = req.tag;
                exp_rsp.push_back(want);
            end
            if (vec_mem[base+6][0]) begin
                la.tag   = req.addr.tag;
                la.index = req.addr.index;
                exp_fill.push_back(la);
                want_fills++;
            end
        end
        #1;
        core_req_valid = 1'b0;
    endtask

    task automatic begin_test(input int num);
        test_num     = num;
        cur_test     = test_name(num);
        err_base     = errors;
        chk_base     = checks;
        fill_base    = fill_count;
        wr_base      = write_count;
        want_fills   = 0;
        want_writes  = 0;
        backpressure <= (num == 6);
    endtask

    // drain all outstanding traffic, then report the test
    task automatic end_test();
        int cycles;
        cycles = 0;
        while ((exp_rsp.size() + exp_wr.size() + exp_fill.size() + fill_pending.size()) != 0
               && !timed_out) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles >= timeout) begin
                $display("timeout: %s still waiting for responses or memory requests",
                         cur_test);
                timed_out = 1'b1;
            end
        end
        check_value("fill count", want_fills, fill_count - fill_base);
        check_value("write count", want_writes, write_count - wr_base);
        tests++;
        $display("test %0d %s: %0d checks, %0d errors", test_num, cur_test,
                 checks - chk_base, errors - err_base);
    endtask

    initial begin : main
        int num;
        clk            = 1'b0;
        rst_n          = 1'b0;
        core_req_valid = 1'b0;
        core_req       = '0;
        core_rsp_ready = 1'b1;
        mem_req_ready  = 1'b1;
        backpressure   = 1'b0;
        timed_out      = 1'b0;
        checks         = 0;
        errors         = 0;
        tests          = 0;
        fill_count     = 0;
        write_count    = 0;
        test_num       = 0;
        cur_test       = "reset";
        for (int a = 0; a < (1 << cache_pkg::addr_bits); a++) begin
            mem_model[a] = cache_pkg::word_t'(a) ^ init_pattern;
        end
        $readmemh("test/cache_bank_vectors.txt", vec_mem);
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // the first request waits out the init sweep on core_req_ready
        for (int v = 0; v < num_vectors && !timed_out; v++) begin
            num = int'(vec_mem[v * vec_words]);
            if (num != test_num) begin
                if (test_num != 0) begin
                    end_test();
                end
                begin_test(num);
            end
            send_request(v);
        end
        end_test();
        $display("summary: %0d tests, %0d checks, %0d errors, %0d fills, %0d writes",
                 tests, checks, errors, fill_count, write_count);
        if (errors == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
common/cache_pkg.sv
design/sync_fifo.sv
design/cache_init.sv
design/cache_miss_slot.sv
store/cache_tags.sv
store/cache_data.sv
design/cache_bank.sv
test/cache_bank_tb.sv

// ==== test/cache_bank_vectors.txt ====
// columns: test, op (0 read, 1 write), word address, byte enables, write data,
// expected read data, fill expected (1 when the read must fetch its line)
1 0 010 F 00000000 5A5A0010 1
1 0 123 F 00000000 5A5A0123 1
2 0 011 F 00000000 5A5A0011 0
2 0 013 F 00000000 5A5A0013 0
2 0 012 F 00000000 5A5A0012 0
2 0 120 F 00000000 5A5A0120 0
3 1 011 3 CAFE1234 00000000 0
3 1 2A6 C 89AB0000 00000000 0
3 1 7FF 1 000000EE 00000000 0
3 1 013 8 11000000 00000000 0
4 0 011 F 00000000 5A5A1234 0
4 0 013 F 00000000 115A0013 0
4 1 012 6 00ABCD00 00000000 0
4 0 012 F 00000000 5AABCD12 0
4 0 2A6 F 00000000 89AB02A6 1
4 0 7FF F 00000000 5A5A07EE 1
4 1 2A5 F 01020304 00000000 0
4 0 2A5 F 00000000 01020304 0
5 0 051 F 00000000 5A5A0051 1
5 0 011 F 00000000 5A5A1234 1
5 0 052 F 00000000 5A5A0052 1
5 0 013 F 00000000 115A0013 1
5 0 050 F 00000000 5A5A0050 1
6 0 050 F 00000000 5A5A0050 0
6 0 051 F 00000000 5A5A0051 0
6 0 052 F 00000000 5A5A0052 0
6 1 050 F 0BADF00D 00000000 0
6 0 050 F 00000000 0BADF00D 0
6 0 120 F 00000000 5A5A0120 0
6 0 012 F 00000000 5AABCD12 1
6 0 013 F 00000000 115A0013 0
6 0 2A6 F 00000000 89AB02A6 0
